//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/control.sv
`timescale 1ns/1ps

module control (
	input  logic [31:0]     inst,
	output mips_pkg::ctrl_t ctrl
);

	logic [5:0] op; // primary opcode
	logic [5:0] fn; // special function

	assign op = inst[31:26];
	assign fn = inst[5:0];

	// register-register alu row with result to rd
	function automatic mips_pkg::ctrl_t r_alu(input mips_pkg::alu_op_t alu_op);
		mips_pkg::ctrl_t c;
		c = '0;
		c.alu_op = alu_op;
		c.wb_we = 1'b1;
		c.dreg = mips_pkg::dreg_rd;
		return c;
	endfunction

	// immediate alu row with result to rt
	function automatic mips_pkg::ctrl_t i_alu(input mips_pkg::alu_op_t alu_op,
			input logic sext);
		mips_pkg::ctrl_t c;
		c = '0;
		c.imm_sel = 1'b1;
		c.imm_sign = sext;
		c.alu_op = alu_op;
		c.wb_we = 1'b1;
		c.dreg = mips_pkg::dreg_rt;
		return c;
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.unknown = 1'b1; // anything not listed below
		case (op)
			mips_pkg::op_special: begin
				case (fn)
					mips_pkg::fn_sll:  ctrl = r_alu(mips_pkg::alu_sll);
					mips_pkg::fn_srl:  ctrl = r_alu(mips_pkg::alu_srl);
					mips_pkg::fn_addu: ctrl = r_alu(mips_pkg::alu_add);
					mips_pkg::fn_subu: ctrl = r_alu(mips_pkg::alu_sub);
					mips_pkg::fn_and:  ctrl = r_alu(mips_pkg::alu_and);
					mips_pkg::fn_or:   ctrl = r_alu(mips_pkg::alu_or);
					mips_pkg::fn_xor:  ctrl = r_alu(mips_pkg::alu_xor);
					mips_pkg::fn_nor:  ctrl = r_alu(mips_pkg::alu_nor);
					mips_pkg::fn_slt:  ctrl = r_alu(mips_pkg::alu_slt);
					mips_pkg::fn_sltu: ctrl = r_alu(mips_pkg::alu_sltu);
					mips_pkg::fn_jr: begin
						ctrl = '0;
						ctrl.jump_reg = 1'b1; // target from rs
					end
					mips_pkg::fn_syscall: begin
						ctrl = '0;
						ctrl.syscall = 1'b1; // stops the core
					end
					default: ;
				endcase
			end
			mips_pkg::op_j: begin
				ctrl = '0;
				ctrl.jump = 1'b1;
			end
			mips_pkg::op_jal: begin
				ctrl = '0;
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.wb_we = 1'b1;
				ctrl.dreg = mips_pkg::dreg_ra; // r31
			end
			mips_pkg::op_beq: begin
				ctrl = '0;
				ctrl.bcond = mips_pkg::bc_eq;
			end
			mips_pkg::op_bne: begin
				ctrl = '0;
				ctrl.bcond = mips_pkg::bc_ne;
			end
			mips_pkg::op_addiu: ctrl = i_alu(mips_pkg::alu_add, 1'b1);
			mips_pkg::op_slti:  ctrl = i_alu(mips_pkg::alu_slt, 1'b1);
			mips_pkg::op_sltiu: ctrl = i_alu(mips_pkg::alu_sltu, 1'b1);
			mips_pkg::op_andi:  ctrl = i_alu(mips_pkg::alu_and, 1'b0); // logic ops zero extend
			mips_pkg::op_ori:   ctrl = i_alu(mips_pkg::alu_or, 1'b0);
			mips_pkg::op_xori:  ctrl = i_alu(mips_pkg::alu_xor, 1'b0);
			mips_pkg::op_lui: begin
				ctrl = i_alu(mips_pkg::alu_or, 1'b0);
				ctrl.lui = 1'b1;
			end
			mips_pkg::op_lw: begin
				ctrl = i_alu(mips_pkg::alu_add, 1'b1); // rs + offset
				ctrl.mem_op = mips_pkg::mem_read;
			end
			mips_pkg::op_sw: begin
				ctrl = i_alu(mips_pkg::alu_add, 1'b1);
				ctrl.wb_we = 1'b0;
				ctrl.dreg = mips_pkg::dreg_none;
				ctrl.mem_op = mips_pkg::mem_write;
			end
			default: ;
		endcase
	end

endmodule

//--- design/exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input  logic        clk,
	input  logic        rst,
	input  logic        inst_valid,
	input  logic [31:0] inst,
	input  logic [31:0] inst_pc,
	output logic        inst_ready,
	output logic        redirect,
	output logic [31:0] redirect_pc,
	output logic        ls_valid,
	input  logic        ls_ready,
	output logic        ls_we,
	output logic [31:0] ls_addr,
	output logic [31:0] ls_wdata,
	input  logic        ld_valid,
	input  logic [31:0] ld_data,
	output logic        halted,
	output logic        fault,
	output logic [31:0] fault_pc
);

	typedef enum logic [1:0] {st_idle, st_exec, st_load, st_halt} state_t;

	state_t          state;
	logic [31:0]     ir;        // accepted instruction
	logic [31:0]     ir_pc;
	mips_pkg::ctrl_t ctrl;
	logic [31:0]     regs [32];
	logic [4:0]      rs, rt, rd, shamt, wreg;
	logic [31:0]     a, rt_val, b, imm, alu_res, pc4, wb_val;
	logic            is_mem, bad_addr, take, wb_en;

	control i_control (
		.inst (ir),
		.ctrl (ctrl)
	);

	assign rs    = ir[25:21];
	assign rt    = ir[20:16];
	assign rd    = ir[15:11];
	assign shamt = ir[10:6];

	assign a      = (rs == 5'd0) ? 32'd0 : regs[rs]; // r0 reads zero
	assign rt_val = (rt == 5'd0) ? 32'd0 : regs[rt];
	assign imm    = ctrl.imm_sign ? {{16{ir[15]}}, ir[15:0]} : {16'd0, ir[15:0]};
	assign b      = ctrl.imm_sel ? imm : rt_val;
	assign pc4    = ir_pc + 32'd4; // no delay slot

	always_comb begin
		case (ctrl.alu_op)
			mips_pkg::alu_and:  alu_res = a & b;
			mips_pkg::alu_or:   alu_res = a | b;
			mips_pkg::alu_add:  alu_res = a + b;
			mips_pkg::alu_xor:  alu_res = a ^ b;
			mips_pkg::alu_nor:  alu_res = ~(a | b);
			mips_pkg::alu_srl:  alu_res = b >> shamt; // shifts act on rt
			mips_pkg::alu_sub:  alu_res = a - b;
			mips_pkg::alu_slt:  alu_res = {31'd0, $signed(a) < $signed(b)};
			mips_pkg::alu_sll:  alu_res = b << shamt;
			mips_pkg::alu_sltu: alu_res = {31'd0, a < b};
			default:            alu_res = '0;
		endcase
	end

	always_comb begin
		case (ctrl.bcond)
			mips_pkg::bc_eq: take = (a == rt_val);
			mips_pkg::bc_ne: take = (a != rt_val);
			default:         take = 1'b0;
		endcase
	end

	always_comb begin
		case (ctrl.dreg)
			mips_pkg::dreg_rd: wreg = rd;
			mips_pkg::dreg_rt: wreg = rt;
			mips_pkg::dreg_ra: wreg = 5'd31;
			default:           wreg = 5'd0; // dropped by r0 guard
		endcase
	end

	// out of range or unaligned access faults like an unknown opcode
	assign is_mem   = (ctrl.mem_op != mips_pkg::mem_none);
	assign bad_addr = is_mem && (alu_res[1:0] != 2'b00 || alu_res[31:2] >= mips_pkg::MEM_WORDS);

	assign inst_ready = (state == st_idle);
	assign halted     = (state == st_halt);
	assign redirect   = (state == st_exec) && (take || ctrl.jump || ctrl.jump_reg);
	assign redirect_pc = ctrl.jump_reg ? a :
		ctrl.jump ? {pc4[31:28], ir[25:0], 2'b00} :
		pc4 + {{14{ir[15]}}, ir[15:0], 2'b00};

	assign ls_valid = (state == st_exec) && is_mem && !bad_addr;
	assign ls_we    = (ctrl.mem_op == mips_pkg::mem_write);
	assign ls_addr  = alu_res;
	assign ls_wdata = rt_val;

	assign wb_val = (state == st_load) ? ld_data :
		ctrl.link ? pc4 :
		ctrl.lui ? {ir[15:0], 16'd0} : alu_res;
	assign wb_en = ((state == st_exec) && ctrl.wb_we && !is_mem) ||
		((state == st_load) && ld_valid);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			fault <= 1'b0;
			fault_pc <= '0;
		end else begin
			case (state)
				st_idle: if (inst_valid) state <= st_exec;
				st_exec: begin
					if (ctrl.syscall)
						state <= st_halt;
					else if (ctrl.unknown || bad_addr) begin
						state <= st_halt;
						fault <= 1'b1;
						fault_pc <= ir_pc;
					end else if (ls_valid) begin
						if (ls_ready)
							state <= ls_we ? st_idle : st_load; // store is fire and forget
					end else
						state <= st_idle;
				end
				st_load: if (ld_valid) state <= st_idle;
				default: ; // halt is sticky until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid && inst_ready) begin
			ir <= inst;
			ir_pc <= inst_pc;
		end
		if (wb_en && wreg != 5'd0)
			regs[wreg] <= wb_val;
	end

	// load data from the lsu only while a load waits for it
	a_load_reply: assert property (@(posedge clk) disable iff (rst)
		ld_valid |-> state == st_load);

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic        clk,
	input  logic        rst,
	input  logic        run,
	mem_if.requester    mem,
	output logic        inst_valid,
	output logic [31:0] inst,
	output logic [31:0] inst_pc,
	input  logic        inst_ready,
	input  logic        redirect,
	input  logic [31:0] redirect_pc
);

	logic [31:0] fetch_pc;  // next word to ask for
	logic [31:0] pend_pc;   // pc of the word in flight
	logic        pending;   // one request outstanding
	logic        gen;       // flips on redirect
	logic        pend_gen;  // gen when request went out
	logic        rsp_keep;  // response is still wanted
	logic        buf_valid;
	logic [31:0] buf_inst;
	logic [31:0] buf_pc;

	assign rsp_keep = mem.rsp_valid && (pend_gen == gen);

	// ask when the buffer is empty or drains this cycle
	assign mem.req_valid = run && !pending && (!buf_valid || inst_ready) && !redirect;
	assign mem.req_we    = 1'b0;
	assign mem.req_addr  = fetch_pc[mips_pkg::ADDR_W+1:2];
	assign mem.req_wdata = '0;

	assign inst_valid = buf_valid;
	assign inst       = buf_inst;
	assign inst_pc    = buf_pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= '0; // programs start at 0
			pending <= 1'b0;
			gen <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (mem.rsp_valid)
				pending <= 1'b0;
			if (mem.req_valid && mem.req_ready) begin
				pending <= 1'b1;
				fetch_pc <= fetch_pc + 32'd4;
			end
			if (inst_valid && inst_ready)
				buf_valid <= 1'b0;
			if (rsp_keep)
				buf_valid <= 1'b1;
			if (redirect) begin
				buf_valid <= 1'b0; // drop the sequential guess
				fetch_pc <= redirect_pc;
				gen <= ~gen; // stale response is ignored
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem.req_valid && mem.req_ready) begin
			pend_pc <= fetch_pc;
			pend_gen <= gen;
		end
		if (rsp_keep) begin
			buf_inst <= mem.rsp_data;
			buf_pc <= pend_pc;
		end
	end

endmodule

//--- design/lsu.sv
`timescale 1ns/1ps

module lsu (
	input  logic        clk,
	input  logic        rst,
	input  logic        ls_valid,
	input  logic        ls_we,
	input  logic [31:0] ls_addr,
	input  logic [31:0] ls_wdata,
	output logic        ls_ready,
	output logic        ld_valid,
	output logic [31:0] ld_data,
	mem_if.requester    mem
);

	logic                        pend;     // request waiting for grant
	logic                        ld_wait;  // read taken, data next
	logic                        pend_we;
	logic [mips_pkg::ADDR_W-1:0] pend_addr;
	logic [31:0]                 pend_wdata;

	assign ls_ready = !pend && !ld_wait;

	assign mem.req_valid = pend;
	assign mem.req_we    = pend_we;
	assign mem.req_addr  = pend_addr;
	assign mem.req_wdata = pend_wdata;

	assign ld_valid = ld_wait && mem.rsp_valid;
	assign ld_data  = mem.rsp_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			ld_wait <= 1'b0;
		end else begin
			if (ls_valid && ls_ready)
				pend <= 1'b1;
			else if (mem.req_valid && mem.req_ready) begin
				pend <= 1'b0;
				ld_wait <= !pend_we; // writes get no response
			end
			if (ld_valid)
				ld_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ls_valid && ls_ready) begin
			pend_we <= ls_we;
			pend_addr <= ls_addr[mips_pkg::ADDR_W+1:2]; // byte to word
			pend_wdata <= ls_wdata;
		end
	end

	// byte lanes are dropped, the core must only hand over whole words
	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		ls_valid |-> ls_addr[1:0] == 2'b00);

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                        clk,
	input  logic                        rst,
	mem_if.arbiter                      req [mips_pkg::N_REQ],
	output logic                        mem_we,
	output logic [mips_pkg::ADDR_W-1:0] mem_addr,
	output logic [31:0]                 mem_wdata,
	output logic                        mem_en,
	input  logic [31:0]                 mem_rdata
);

	typedef logic [$clog2(mips_pkg::N_REQ)-1:0] idx_t;

	logic [mips_pkg::N_REQ-1:0]  valid;
	logic [mips_pkg::N_REQ-1:0]  we;
	logic [mips_pkg::N_REQ-1:0]  grant;
	logic [mips_pkg::ADDR_W-1:0] addr [mips_pkg::N_REQ];
	logic [31:0]                 wdata [mips_pkg::N_REQ];
	idx_t                        prio;      // first in line
	idx_t                        gnt_idx;
	idx_t                        rsp_owner; // who gets next cycle's data
	logic                        rsp_due;

	for (genvar i = 0; i < mips_pkg::N_REQ; i++) begin : g_req
		assign valid[i] = req[i].req_valid;
		assign we[i]    = req[i].req_we;
		assign addr[i]  = req[i].req_addr;
		assign wdata[i] = req[i].req_wdata;
		assign req[i].req_ready = grant[i];
		assign req[i].rsp_valid = rsp_due && (rsp_owner == idx_t'(i));
		assign req[i].rsp_data  = mem_rdata;
	end

	// nearest valid from prio wins
	always_comb begin
		int idx;
		grant = '0;
		gnt_idx = prio;
		for (int k = mips_pkg::N_REQ - 1; k >= 0; k--) begin
			idx = (int'(prio) + k) % mips_pkg::N_REQ;
			if (valid[idx]) begin
				grant = '0;
				grant[idx] = 1'b1;
				gnt_idx = idx_t'(idx);
			end
		end
	end

	assign mem_en    = |grant;
	assign mem_we    = we[gnt_idx];
	assign mem_addr  = addr[gnt_idx];
	assign mem_wdata = wdata[gnt_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			prio <= '0;
			rsp_due <= 1'b0;
		end else begin
			rsp_due <= mem_en && !mem_we; // read data lands next cycle
			if (mem_en)
				prio <= (gnt_idx == idx_t'(mips_pkg::N_REQ - 1)) ? '0 : gnt_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_en)
			rsp_owner <= gnt_idx;
	end

	// two cycles of waiting at most, the third grant is its own
	for (genvar i = 0; i < mips_pkg::N_REQ; i++) begin : g_fair
		a_wait_bounded: assert property (@(posedge clk) disable iff (rst)
			valid[i] && !grant[i] && $past(valid[i] && !grant[i]) |=>
				grant[i] || !valid[i]);
	end

endmodule

//--- design/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
	logic                        req_valid;
	logic                        req_ready;
	logic                        req_we;
	logic [mips_pkg::ADDR_W-1:0] req_addr;  // word address
	logic [31:0]                 req_wdata;
	logic                        rsp_valid; // one cycle after a read is taken
	logic [31:0]                 rsp_data;

	modport requester (
		output req_valid, req_we, req_addr, req_wdata,
		input  req_ready, rsp_valid, rsp_data
	);

	modport arbiter (
		input  req_valid, req_we, req_addr, req_wdata,
		output req_ready, rsp_valid, rsp_data
	);
endinterface

//--- design/mips_pkg.sv
package mips_pkg;

	localparam int MEM_WORDS = 1024; // words in the shared memory
	localparam int ADDR_W    = 10;   // word address bits
	localparam int N_REQ     = 3;    // fetch, lsu, host

	//////////////////////////////////////////////////
	// primary opcodes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j       = 6'h02;
	localparam logic [5:0] op_jal     = 6'h03;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_bne     = 6'h05;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_slti    = 6'h0a;
	localparam logic [5:0] op_sltiu   = 6'h0b;
	localparam logic [5:0] op_andi    = 6'h0c;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_xori    = 6'h0e;
	localparam logic [5:0] op_lui     = 6'h0f;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_sw      = 6'h2b;

	// function field of op_special
	localparam logic [5:0] fn_sll     = 6'h00;
	localparam logic [5:0] fn_srl     = 6'h02;
	localparam logic [5:0] fn_jr      = 6'h08;
	localparam logic [5:0] fn_syscall = 6'h0c;
	localparam logic [5:0] fn_addu    = 6'h21;
	localparam logic [5:0] fn_subu    = 6'h23;
	localparam logic [5:0] fn_and     = 6'h24;
	localparam logic [5:0] fn_or      = 6'h25;
	localparam logic [5:0] fn_xor     = 6'h26;
	localparam logic [5:0] fn_nor     = 6'h27;
	localparam logic [5:0] fn_slt     = 6'h2a;
	localparam logic [5:0] fn_sltu    = 6'h2b;

	//////////////////////////////////////////////////
	// decoded control word
	typedef enum logic [3:0] {
		alu_and  = 4'b0000,
		alu_or   = 4'b0001,
		alu_add  = 4'b0010,
		alu_xor  = 4'b0011,
		alu_nor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_sub  = 4'b0110,
		alu_slt  = 4'b0111,
		alu_sll  = 4'b1000,
		alu_sltu = 4'b1010 // 4'b1001 left unused
	} alu_op_t;

	typedef enum logic [1:0] {bc_none, bc_eq, bc_ne} bcond_t;
	typedef enum logic [1:0] {dreg_none, dreg_rd, dreg_rt, dreg_ra} dreg_t;
	typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_t;

	typedef struct packed {
		bcond_t  bcond;    // branch compare
		logic    jump;     // j / jal target
		logic    jump_reg; // jr
		logic    imm_sel;  // b operand is immediate
		logic    imm_sign; // sign extend immediate
		alu_op_t alu_op;
		logic    lui;      // result is imm << 16
		logic    link;     // result is pc + 4
		mem_op_t mem_op;
		logic    wb_we;    // register write
		dreg_t   dreg;     // which register
		logic    syscall;
		logic    unknown;
	} ctrl_t;

endpackage

//--- design/mips_top.sv
`timescale 1ns/1ps

module mips_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        run,
	input  logic                        host_valid,
	output logic                        host_ready,
	input  logic                        host_we,
	input  logic [mips_pkg::ADDR_W-1:0] host_addr,  // word address
	input  logic [31:0]                 host_wdata,
	output logic                        host_rvalid,
	output logic [31:0]                 host_rdata,
	output logic                        halted,
	output logic                        fault,
	output logic [31:0]                 fault_pc
);

	mem_if m_if [mips_pkg::N_REQ] (); // 0 fetch, 1 lsu, 2 host

	logic                        inst_valid, inst_ready;
	logic [31:0]                 inst, inst_pc;
	logic                        redirect;
	logic [31:0]                 redirect_pc;
	logic                        ls_valid, ls_ready, ls_we;
	logic [31:0]                 ls_addr, ls_wdata;
	logic                        ld_valid;
	logic [31:0]                 ld_data;
	logic                        mem_en, mem_we;
	logic [mips_pkg::ADDR_W-1:0] mem_addr;
	logic [31:0]                 mem_wdata, mem_rdata;

	//////////////////////////////////////////////////
	// host port onto the third requester
	assign m_if[2].req_valid = host_valid;
	assign m_if[2].req_we    = host_we;
	assign m_if[2].req_addr  = host_addr;
	assign m_if[2].req_wdata = host_wdata;
	assign host_ready  = m_if[2].req_ready;
	assign host_rvalid = m_if[2].rsp_valid;
	assign host_rdata  = m_if[2].rsp_data;

	fetch_unit i_fetch (
		.clk, .rst, .run,
		.mem         (m_if[0]),
		.inst_valid, .inst, .inst_pc, .inst_ready,
		.redirect, .redirect_pc
	);

	exec_core i_exec (
		.clk, .rst,
		.inst_valid, .inst, .inst_pc, .inst_ready,
		.redirect, .redirect_pc,
		.ls_valid, .ls_ready, .ls_we, .ls_addr, .ls_wdata,
		.ld_valid, .ld_data,
		.halted, .fault, .fault_pc
	);

	lsu i_lsu (
		.clk, .rst,
		.ls_valid, .ls_we, .ls_addr, .ls_wdata, .ls_ready,
		.ld_valid, .ld_data,
		.mem         (m_if[1])
	);

	mem_arbiter i_arb (
		.clk, .rst,
		.req         (m_if),
		.mem_we, .mem_addr, .mem_wdata, .mem_en, .mem_rdata
	);

	word_mem i_mem (
		.clk,
		.en          (mem_en),
		.we          (mem_we),
		.addr        (mem_addr),
		.wdata       (mem_wdata),
		.rdata       (mem_rdata)
	);

endmodule

//--- design/word_mem.sv
`timescale 1ns/1ps

module word_mem (
	input  logic                        clk,
	input  logic                        en,
	input  logic                        we,
	input  logic [mips_pkg::ADDR_W-1:0] addr,
	input  logic [31:0]                 wdata,
	output logic [31:0]                 rdata
);

	logic [31:0] mem [mips_pkg::MEM_WORDS];

	// single port, registered read
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // holds last read otherwise
		end
	end

endmodule

//--- filelist.f
design/mips_pkg.sv
design/mem_if.sv
design/control.sv
design/fetch_unit.sv
design/exec_core.sv
design/lsu.sv
design/mem_arbiter.sv
design/word_mem.sv
design/mips_top.sv
verif/tb_clock.sv
verif/tb_mips.sv

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// free running, 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // half period
	end

endmodule

//--- verif/tb_mips.sv
`timescale 1ns/1ps

module tb_mips;

	localparam int data_word = 512;  // result area above every program
	localparam int alu_len   = 39;   // static length of each program
	localparam int loop_len  = 12;
	localparam int ldst_len  = 8;
	localparam int fault_len = 7;
	localparam int wd_cycles = 200 * (alu_len + loop_len + ldst_len + fault_len);
	localparam logic [31:0] sentinel = 32'h5a5a_a5a5; // marks untouched words

	logic                        clk;
	logic                        rst, run;
	logic                        host_valid, host_ready, host_we, host_rvalid;
	logic [mips_pkg::ADDR_W-1:0] host_addr;
	logic [31:0]                 host_wdata, host_rdata;
	logic                        halted, fault;
	logic [31:0]                 fault_pc;
	integer                      seed;
	logic [31:0]                 prog [$];   // program being assembled
	logic [31:0]                 exp_q [$];  // alu results in store order
	string                       name_q [$];

	tb_clock i_clock (.clk);

	mips_top i_dut (
		.clk, .rst, .run,
		.host_valid, .host_ready, .host_we, .host_addr, .host_wdata,
		.host_rvalid, .host_rdata,
		.halted, .fault, .fault_pc
	);

	task automatic fail_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] expv,
			input logic [31:0] actv);
		assert (actv === expv)
		else begin
			$display("FAIL %s expected %08h actual %08h", name, expv, actv);
			fail_run();
		end
	endtask

	//////////////////////////////////////////////////
	// assembler
	function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		return {mips_pkg::op_special, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] target);
		return {op, target}; // word index of the target
	endfunction

	function automatic logic [15:0] data_off(input int k);
		return 16'((data_word + k) * 4); // byte offset from r0
	endfunction

	function automatic logic [mips_pkg::ADDR_W-1:0] data_addr(input int k);
		return mips_pkg::ADDR_W'(data_word + k);
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// one alu instruction into r3 and its store
	task automatic alu_case(input string name, input logic [31:0] word,
			input logic [31:0] expv);
		emit(word);
		emit(itype(mips_pkg::op_sw, 5'd3, 5'd0, data_off(exp_q.size())));
		exp_q.push_back(expv);
		name_q.push_back(name);
	endtask

	//////////////////////////////////////////////////
	// host port and run control
	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		run = 1'b0; // core idle while memory is loaded
		repeat (16) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic host_write(input logic [mips_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		host_valid = 1'b1;
		host_we = 1'b1;
		host_addr = addr;
		host_wdata = data;
		@(posedge clk);
		while (!host_ready) @(posedge clk); // wait for grant
		@(negedge clk);
		host_valid = 1'b0;
		host_we = 1'b0;
	endtask

	task automatic host_read(input logic [mips_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		host_valid = 1'b1;
		host_we = 1'b0;
		host_addr = addr;
		@(posedge clk);
		while (!host_ready) @(posedge clk);
		@(negedge clk);
		host_valid = 1'b0;
		@(posedge clk);
		while (!host_rvalid) @(posedge clk);
		data = host_rdata;
	endtask

	task automatic expect_mem(input string name, input int k, input logic [31:0] expv);
		logic [31:0] got;
		host_read(data_addr(k), got);
		check_word(name, expv, got);
	endtask

	task automatic load_program();
		apply_reset();
		foreach (prog[i])
			host_write(mips_pkg::ADDR_W'(i), prog[i]);
	endtask

	task automatic launch();
		@(negedge clk);
		run = 1'b1; // fetch starts at 0
	endtask

	task automatic wait_halt();
		@(posedge clk);
		while (!halted) @(posedge clk);
	endtask

	//////////////////////////////////////////////////
	// tests
	task automatic test_host_rw();
		logic [mips_pkg::ADDR_W-1:0] addr;
		logic [31:0]                 wd, rd;
		for (int i = 0; i < 8; i++) begin
			addr = mips_pkg::ADDR_W'(256 + ($random(seed) & 255)); // clear of programs
			wd = $random(seed);
			host_write(addr, wd);
			host_read(addr, rd);
			check_word("host_rw", wd, rd);
		end
	endtask

	task automatic test_alu();
		logic [31:0] x, y, sx, zx, got;
		logic [15:0] imm;
		logic [4:0]  sh;
		x = $random(seed);
		y = $random(seed);
		imm = 16'($random(seed));
		sh = 5'($random(seed));
		sx = {{16{imm[15]}}, imm};
		zx = {16'd0, imm};
		prog.delete();
		exp_q.delete();
		name_q.delete();
		emit(itype(mips_pkg::op_lui, 5'd1, 5'd0, x[31:16])); // r1 = x
		emit(itype(mips_pkg::op_ori, 5'd1, 5'd1, x[15:0]));
		emit(itype(mips_pkg::op_lui, 5'd2, 5'd0, y[31:16])); // r2 = y
		emit(itype(mips_pkg::op_ori, 5'd2, 5'd2, y[15:0]));
		alu_case("alu_addu", rtype(mips_pkg::fn_addu, 5'd3, 5'd1, 5'd2, 5'd0), x + y);
		alu_case("alu_subu", rtype(mips_pkg::fn_subu, 5'd3, 5'd1, 5'd2, 5'd0), x - y);
		alu_case("alu_and", rtype(mips_pkg::fn_and, 5'd3, 5'd1, 5'd2, 5'd0), x & y);
		alu_case("alu_or", rtype(mips_pkg::fn_or, 5'd3, 5'd1, 5'd2, 5'd0), x | y);
		alu_case("alu_xor", rtype(mips_pkg::fn_xor, 5'd3, 5'd1, 5'd2, 5'd0), x ^ y);
		alu_case("alu_nor", rtype(mips_pkg::fn_nor, 5'd3, 5'd1, 5'd2, 5'd0), ~(x | y));
		alu_case("alu_slt", rtype(mips_pkg::fn_slt, 5'd3, 5'd1, 5'd2, 5'd0),
			{31'd0, $signed(x) < $signed(y)});
		alu_case("alu_sltu", rtype(mips_pkg::fn_sltu, 5'd3, 5'd1, 5'd2, 5'd0), {31'd0, x < y});
		alu_case("alu_sll", rtype(mips_pkg::fn_sll, 5'd3, 5'd0, 5'd2, sh), y << sh);
		alu_case("alu_srl", rtype(mips_pkg::fn_srl, 5'd3, 5'd0, 5'd2, sh), y >> sh);
		alu_case("alu_addiu", itype(mips_pkg::op_addiu, 5'd3, 5'd1, imm), x + sx);
		alu_case("alu_slti", itype(mips_pkg::op_slti, 5'd3, 5'd1, imm),
			{31'd0, $signed(x) < $signed(sx)});
		alu_case("alu_sltiu", itype(mips_pkg::op_sltiu, 5'd3, 5'd1, imm), {31'd0, x < sx});
		alu_case("alu_andi", itype(mips_pkg::op_andi, 5'd3, 5'd1, imm), x & zx);
		alu_case("alu_ori", itype(mips_pkg::op_ori, 5'd3, 5'd1, imm), x | zx);
		alu_case("alu_xori", itype(mips_pkg::op_xori, 5'd3, 5'd1, imm), x ^ zx);
		alu_case("alu_lui", itype(mips_pkg::op_lui, 5'd3, 5'd0, imm), {imm, 16'd0});
		emit(rtype(mips_pkg::fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
		load_program();
		launch();
		wait_halt();
		for (int i = 0; i < exp_q.size(); i++) begin
			host_read(data_addr(i), got);
			check_word(name_q[i], exp_q[i], got);
		end
		check_word("alu_fault_flag", 32'd0, {31'd0, fault});
	endtask

	// sum loop and jal/jr with host traffic while running
	task automatic test_loop();
		int          n;
		logic [31:0] got;
		n = 20 + ($random(seed) & 15);
		prog.delete();
		emit(itype(mips_pkg::op_addiu, 5'd1, 5'd0, 16'(n))); // counter
		emit(rtype(mips_pkg::fn_addu, 5'd2, 5'd0, 5'd0, 5'd0)); // sum = 0
		emit(rtype(mips_pkg::fn_addu, 5'd2, 5'd2, 5'd1, 5'd0)); // loop head at word 2
		emit(itype(mips_pkg::op_addiu, 5'd1, 5'd1, 16'hffff));
		emit(itype(mips_pkg::op_bne, 5'd0, 5'd1, 16'hfffd)); // back 3 words
		emit(itype(mips_pkg::op_sw, 5'd2, 5'd0, data_off(0)));
		emit(jtype(mips_pkg::op_jal, 26'd9)); // word 6
		emit(itype(mips_pkg::op_sw, 5'd31, 5'd0, data_off(1)));
		emit(rtype(mips_pkg::fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
		emit(jtype(mips_pkg::op_j, 26'd11)); // subroutine
		emit(itype(mips_pkg::op_sw, 5'd2, 5'd0, data_off(2))); // jumped over
		emit(rtype(mips_pkg::fn_jr, 5'd0, 5'd31, 5'd0, 5'd0));
		load_program();
		for (int k = 0; k < 3; k++)
			host_write(data_addr(k), sentinel);
		launch();
		for (int i = 0; i < 4; i++) begin
			host_read(mips_pkg::ADDR_W'(i), got);
			assert (!halted)
			else begin
				$display("host read %0d was answered only after the core halted", i);
				fail_run();
			end
			check_word("host_read_while_running", prog[i], got);
		end
		wait_halt();
		expect_mem("loop_sum", 0, 32'(n * (n + 1) / 2));
		expect_mem("jal_link", 1, 32'(6 * 4 + 4)); // pc of jal plus 4
		expect_mem("j_skip", 2, sentinel);
		check_word("loop_fault_flag", 32'd0, {31'd0, fault});
	endtask

	task automatic test_ldst();
		logic [31:0] x;
		x = $random(seed);
		prog.delete();
		emit(itype(mips_pkg::op_lui, 5'd1, 5'd0, x[31:16]));
		emit(itype(mips_pkg::op_ori, 5'd1, 5'd1, x[15:0]));
		emit(itype(mips_pkg::op_sw, 5'd1, 5'd0, data_off(0)));
		emit(itype(mips_pkg::op_lw, 5'd2, 5'd0, data_off(0))); // right behind the store
		emit(itype(mips_pkg::op_addiu, 5'd3, 5'd2, 16'd1)); // uses the load
		emit(itype(mips_pkg::op_sw, 5'd2, 5'd0, data_off(1)));
		emit(itype(mips_pkg::op_sw, 5'd3, 5'd0, data_off(2)));
		emit(rtype(mips_pkg::fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
		load_program();
		for (int k = 0; k < 3; k++)
			host_write(data_addr(k), sentinel);
		launch();
		wait_halt();
		expect_mem("sw_data", 0, x);
		expect_mem("lw_data", 1, x);
		expect_mem("lw_use", 2, x + 32'd1);
		check_word("ldst_fault_flag", 32'd0, {31'd0, fault});
	endtask

	task automatic test_fault();
		prog.delete();
		emit(itype(mips_pkg::op_addiu, 5'd1, 5'd0, 16'd5));
		emit(itype(mips_pkg::op_addiu, 5'd2, 5'd1, 16'd7));
		emit(itype(mips_pkg::op_sw, 5'd2, 5'd0, data_off(0)));
		emit({6'h3f, 26'd0}); // opcode with no decode at word 3
		emit(itype(mips_pkg::op_sw, 5'd1, 5'd0, data_off(1)));
		emit(itype(mips_pkg::op_sw, 5'd2, 5'd0, data_off(2)));
		emit(rtype(mips_pkg::fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
		load_program();
		for (int k = 0; k < 3; k++)
			host_write(data_addr(k), sentinel);
		launch();
		wait_halt();
		check_word("fault_flag", 32'd1, {31'd0, fault});
		check_word("fault_pc", 32'd12, fault_pc);
		expect_mem("store_before_fault", 0, 32'd12);
		expect_mem("store_after_fault_a", 1, sentinel);
		expect_mem("store_after_fault_b", 2, sentinel);
	endtask

	//////////////////////////////////////////////////
	// handshake checks
	a_host_rsp_next: assert property (@(posedge clk) disable iff (rst)
		host_valid && host_ready && !host_we |=> host_rvalid)
	else begin
		$display("host read was accepted but no response came on the next cycle");
		fail_run();
	end

	a_host_rsp_owned: assert property (@(posedge clk) disable iff (rst)
		host_rvalid |-> $past(host_valid && host_ready && !host_we))
	else begin
		$display("host response appeared without an accepted host read");
		fail_run();
	end

	a_fault_halts: assert property (@(posedge clk) disable iff (rst) fault |-> halted)
	else begin
		$display("fault flag is set while the core keeps running");
		fail_run();
	end

	initial begin
		seed = 32'hd518;
		rst = 1'b1;
		run = 1'b0;
		host_valid = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		apply_reset();
		test_host_rw();
		test_alu();
		test_loop();
		test_ldst();
		test_fault();
		$display("Test completed successfully");
		$finish;
	end

	// budget scales with program size
	initial begin
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles and the run is stuck", wd_cycles);
		fail_run();
	end

endmodule
